/* Bender.yml */
package:
  name: ramBlock

sources:
  - files:
      - verilog/ramBlockPkg.sv
      - verilog/ramCsr.sv
      - verilog/memoryReadWriteTester.sv
      - verilog/ramReadWriteArbiter.sv
      - verilog/ramIfPortUnit.sv
      - verilog/ramBlock.sv
  - target: test
    files:
      - testbench/sramModel.sv
      - testbench/ramBlockTb.sv

/* ramBlock.f */
verilog/ramBlockPkg.sv
verilog/ramCsr.sv
verilog/memoryReadWriteTester.sv
verilog/ramReadWriteArbiter.sv
verilog/ramIfPortUnit.sv
verilog/ramBlock.sv
testbench/sramModel.sv
testbench/ramBlockTb.sv

/* testbench/ramBlockTb.sv */
`timescale 1ns/1ns
module ramBlockTb import ramBlockPkg::*; ();

localparam int clkPeriod = 4;
localparam int pTestDepth = 16;
localparam logic [7:0] adrsMap = 8'h04;
localparam int maxOps = 64;
localparam int cyclesPerOp = 200;
localparam logic [31:0] statusAdrs = {adrsMap, 24'(regStatus)};

logic sClk;
logic reset;
logic [31:0] usiAdrs;
logic [31:0] usiWd;
logic usiWe;
logic [31:0] usiRd;
sramPinsT sramPins;
logic [ramDqWidth-1:0] sramDq;
logic faultOn;
// Four words per line for op, address, data and expected
logic [31:0] stim [0:4*maxOps-1];
int opCount;
logic loaded;

//------------------------------
// DUT and memory
//------------------------------
ramBlock #(
	.pAdrsMap(adrsMap),
	.pTestDepth(pTestDepth)
) u_ramBlock (
	.usiAdrs(usiAdrs),
	.usiWd(usiWd),
	.usiWe(usiWe),
	.usiRd(usiRd),
	.sramPins(sramPins),
	.sramDq(sramDq),
	.sClk(sClk),
	.reset(reset)
);

sramModel #(
	.pStuckBit(3)
) u_sramModel (
	.adrs(sramPins.adrs),
	.dqIn(sramPins.dq),
	.dqOut(sramDq),
	.oeN(sramPins.oeN),
	.weN(sramPins.weN),
	.ceN(sramPins.ceN),
	.faultOn(faultOn)
);

always #(clkPeriod / 2) sClk = ~sClk;

//------------------------------
// Bus helpers
//------------------------------
task automatic checkValue(input string name, input logic [31:0] actual,
	input logic [31:0] expected);
	if (actual !== expected)
	begin
		$display("FAILED at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
		$display("TB FAILED");
		$fatal(1, "value mismatch");
	end
endtask

// One-cycle write strobe
task automatic busWrite(input logic [31:0] adrs, input logic [31:0] data);
	@(posedge sClk);
	usiAdrs <= adrs;
	usiWd <= data;
	usiWe <= 1'b1;
	@(posedge sClk);
	usiWe <= 1'b0;
endtask

// Data registered one edge after the address and sampled mid-cycle
task automatic busRead(input logic [31:0] adrs, output logic [31:0] data);
	@(posedge sClk);
	usiAdrs <= adrs;
	usiWe <= 1'b0;
	@(posedge sClk);
	@(negedge sClk);
	data = usiRd;
endtask

// Poll status until one bit reaches a level
task automatic waitStatus(input int bitIdx, input logic level);
	logic [31:0] status;
	busRead(statusAdrs, status);
	while (status[bitIdx] !== level)
	begin
		busRead(statusAdrs, status);
	end
endtask

//------------------------------
// Stimulus
//------------------------------
initial
begin
	int idx;
	logic [31:0] op;
	logic [31:0] adrs;
	logic [31:0] data;
	logic [31:0] expVal;
	logic [31:0] rd;
	sClk = 1'b0;
	reset = 1'b1;
	usiAdrs = '0;
	usiWd = '0;
	usiWe = 1'b0;
	faultOn = 1'b0;
	loaded = 1'b0;
	$readmemh("testbench/ramBlock_input.txt", stim);
	// Zero op ends the list
	opCount = 0;
	while (opCount < maxOps && stim[4*opCount] !== 32'h0
		&& !$isunknown(stim[4*opCount]))
	begin
		opCount++;
	end
	if (opCount == 0)
	begin
		$display("Stimulus file is missing or holds no operations");
		$display("TB FAILED");
		$fatal(1, "no stimulus");
	end
	loaded = 1'b1;
	repeat (3) @(posedge sClk);
	reset <= 1'b0;
	@(negedge sClk);
	// Idle pins out of reset
	checkValue("sramPins.ceN", 32'(sramPins.ceN), 32'h1);
	checkValue("sramPins.oeN", 32'(sramPins.oeN), 32'h1);
	checkValue("sramPins.weN", 32'(sramPins.weN), 32'h1);
	checkValue("sramPins.dqOe", 32'(sramPins.dqOe), 32'h0);
	// Both byte lanes stay enabled
	checkValue("sramPins.lbN", 32'(sramPins.lbN), 32'h0);
	checkValue("sramPins.ubN", 32'(sramPins.ubN), 32'h0);
	for (idx = 0; idx < opCount; idx++)
	begin
		op = stim[4*idx];
		adrs = stim[4*idx+1];
		data = stim[4*idx+2];
		expVal = stim[4*idx+3];
		case (op)
			32'h1: busWrite(adrs, data);
			32'h2:
			begin
				busRead(adrs, rd);
				checkValue($sformatf("usiRd[%h]", adrs), rd, expVal);
			end
			32'h3:
			begin
				@(posedge sClk);
				faultOn <= data[0];
			end
			32'h4: waitStatus(2, 1'b0);
			32'h5: waitStatus(0, 1'b1);
			32'h6: checkValue($sformatf("sramModel.mem[%h]", adrs),
				32'(u_sramModel.mem[adrs[ramAdrsWidth-1:0]]), expVal);
			default:
			begin
				$display("Unknown operation %h on stimulus line %0d", op, idx);
				$display("TB FAILED");
				$fatal(1, "bad stimulus");
			end
		endcase
	end
	$display("TB PASSED");
	$finish;
end

// Watchdog budget scales with the file and the self-test depth
initial
begin
	int limit;
	wait (loaded === 1'b1);
	limit = (opCount * cyclesPerOp + pTestDepth * 8) * clkPeriod;
	#(limit);
	$display("Timeout: the run did not finish within %0d ns", limit);
	$display("TB FAILED");
	$fatal(1, "watchdog expired");
end

endmodule

/* testbench/ramBlock_input.txt */
// op address data expected, all hex
// op 1 write, 2 read and check, 3 fault, 4 wait idle, 5 wait done, 6 check model, 0 end
2 04000001 00000000 00000000 // status clear after reset
2 04000000 00000000 00000002 // port enabled
1 04000002 00000123 00000000 // direct write then read back
1 04000003 0000beef 00000000
1 04000004 00000000 00000000
4 00000000 00000000 00000000
1 04000004 00000001 00000000
4 00000000 00000000 00000000
2 04000005 00000000 0000beef
6 00000123 00000000 0000beef
1 05000003 00001234 00000000 // outside the block window
2 05000003 00000000 00000000
2 04000003 00000000 0000beef
1 04000006 00005a5a 00000000 // self-test, clean memory
1 04000000 00000003 00000000
5 00000000 00000000 00000000
2 04000001 00000000 00000001
1 04000002 00000005 00000000
1 04000004 00000001 00000000
4 00000000 00000000 00000000
2 04000005 00000000 00005a5f
6 0000000c 00000000 00005a56
3 00000000 00000001 00000000 // self-test with bit 3 stuck low
1 04000000 00000003 00000000
5 00000000 00000000 00000000
2 04000001 00000000 00000003
3 00000000 00000000 00000000
1 04000000 00000000 00000000 // port off, queue overflow
1 04000004 00000001 00000000
1 04000004 00000001 00000000
1 04000004 00000001 00000000
1 04000004 00000001 00000000
1 04000004 00000001 00000000
2 04000001 00000000 0000000f
1 04000001 00000000 00000000
2 04000001 00000000 00000007
1 04000000 00000002 00000000
4 00000000 00000000 00000000
2 04000001 00000000 00000003
0 00000000 00000000 00000000

/* testbench/sramModel.sv */
`timescale 1ns/1ns
module sramModel import ramBlockPkg::*; #(
	parameter int pStuckBit = 3
)(
	input  logic [ramAdrsWidth-1:0] adrs,
	input  logic [ramDqWidth-1:0] dqIn,
	output logic [ramDqWidth-1:0] dqOut,
	input  logic oeN,
	input  logic weN,
	input  logic ceN,
	// Stuck-at-zero on one data line
	input  logic faultOn
);

// Whole 256K x 16 array
logic [ramDqWidth-1:0] mem [0:(1 << ramAdrsWidth) - 1];
logic [ramDqWidth-1:0] faultMask;

assign faultMask = faultOn ? ~(ramDqWidth'(1) << pStuckBit) : '1;

//------------------------------
// Write path
//------------------------------
// Level sensitive, follows dq while both strobes are low
always @(ceN or weN or adrs or dqIn)
begin
	if (!ceN && !weN)
	begin
		mem[adrs] = dqIn;
	end
end

//------------------------------
// Read path
//------------------------------
// Bus floats unless selected and output enabled
assign dqOut = (!ceN && !oeN) ? (mem[adrs] & faultMask) : 'z;

endmodule

/* verilog/memoryReadWriteTester.sv */
`timescale 1ns/1ns
module memoryReadWriteTester import ramBlockPkg::*; #(
	parameter int pTestDepth = 16
)(
	input  logic sClk,
	input  logic reset,
	input  logic testStart,
	input  logic [ramDqWidth-1:0] testSeed,
	output ramReqT testReq,
	input  logic testGrant,
	input  ramRspT testRsp,
	output logic testActive,
	output logic testDone,
	output logic testErr
);

testStateT state;
logic [ramAdrsWidth-1:0] idx;
logic [ramDqWidth-1:0] seedQ;
logic [ramDqWidth-1:0] pattern;
logic lastIdx;

// Expected word is the address folded with the seed
assign pattern = idx[ramDqWidth-1:0] ^ seedQ;
assign lastIdx = (idx == ramAdrsWidth'(pTestDepth - 1));

// Request decoded from the state and held until granted
always_comb
begin
	testReq.valid = (state == testWrite) || (state == testRead);
	testReq.cmd = (state == testRead) ? ramRead : ramWrite;
	testReq.adrs = idx;
	testReq.wd = pattern;
end

assign testActive = (state == testWrite) || (state == testRead) || (state == testWait);

//------------------------------
// Sequencer
//------------------------------
always_ff @(posedge sClk)
begin
	if (reset)
	begin
		state <= testIdle;
		idx <= '0;
		testErr <= 1'b0;
		testDone <= 1'b0;
	end
	else
	begin
		case (state)
			testIdle, ramBlockPkg::testDone:
			begin
				// New run clears both flags
				if (testStart)
				begin
					state <= testWrite;
					idx <= '0;
					testErr <= 1'b0;
					testDone <= 1'b0;
				end
			end
			testWrite:
			begin
				if (testGrant)
				begin
					// Rewind for readback once the fill pass is done
					idx <= lastIdx ? '0 : idx + 1'b1;
					state <= lastIdx ? testRead : testWrite;
				end
			end
			testRead:
			begin
				if (testGrant)
				begin
					state <= testWait;
				end
			end
			testWait:
			begin
				if (testRsp.valid)
				begin
					if (testRsp.rd != pattern)
					begin
						testErr <= 1'b1;
					end
					idx <= idx + 1'b1;
					// Done flag holds until the next start
					testDone <= lastIdx;
					state <= lastIdx ? ramBlockPkg::testDone : testRead;
				end
			end
			default:
			begin
				state <= testIdle;
			end
		endcase
	end
end

// Seed taken at start
always_ff @(posedge sClk)
begin
	if (testStart && !testActive)
	begin
		seedQ <= testSeed;
	end
end

// Arbiter routing depends on this
doneNotActive: assert property (@(posedge sClk) disable iff (reset)
	!(testDone && testActive))
	else $error("tester done while still active");

endmodule

/* verilog/ramBlock.sv */
`timescale 1ns/1ns
module ramBlock import ramBlockPkg::*; #(
	parameter int pBlockAdrsWidth = 8,
	parameter logic [pBlockAdrsWidth-1:0] pAdrsMap = 8'h04,
	parameter int pBusWidth = 32,
	parameter int pFifoDepth = 4,
	parameter int pTestDepth = 16
)(
	// Bus
	input  logic [pBusWidth-1:0] usiAdrs,
	input  logic [pBusWidth-1:0] usiWd,
	input  logic usiWe,
	output logic [pBusWidth-1:0] usiRd,
	// SRAM pins
	output sramPinsT sramPins,
	input  logic [ramDqWidth-1:0] sramDq,
	input  logic sClk,
	input  logic reset
);

logic testStart;
logic ramEnable;
logic [ramDqWidth-1:0] testSeed;
logic testDone;
logic testErr;
logic testActive;
logic testGrant;
logic queueFull;
logic busy;
logic portBusy;
ramReqT csrReq;
ramReqT testReq;
ramReqT portReq;
ramRspT csrRsp;
ramRspT testRsp;
ramRspT portRsp;

//------------------------------
// Registers
//------------------------------
ramCsr #(
	.pBlockAdrsWidth(pBlockAdrsWidth),
	.pAdrsMap(pAdrsMap),
	.pBusWidth(pBusWidth)
) u_ramCsr (
	.sClk(sClk), .reset(reset),
	.usiAdrs(usiAdrs), .usiWd(usiWd), .usiWe(usiWe), .usiRd(usiRd),
	.testStart(testStart), .ramEnable(ramEnable), .testSeed(testSeed),
	.testDone(testDone), .testErr(testErr),
	.csrReq(csrReq), .queueFull(queueFull), .csrRsp(csrRsp), .busy(busy)
);

// Self-test
memoryReadWriteTester #(
	.pTestDepth(pTestDepth)
) u_memoryReadWriteTester (
	.sClk(sClk), .reset(reset),
	.testStart(testStart), .testSeed(testSeed),
	.testReq(testReq), .testGrant(testGrant), .testRsp(testRsp),
	.testActive(testActive), .testDone(testDone), .testErr(testErr)
);

//------------------------------
// Arbiter and SRAM port
//------------------------------
ramReadWriteArbiter #(
	.pFifoDepth(pFifoDepth)
) u_ramReadWriteArbiter (
	.sClk(sClk), .reset(reset),
	.csrReq(csrReq), .queueFull(queueFull),
	.testReq(testReq), .testActive(testActive), .testGrant(testGrant),
	.portReq(portReq), .portBusy(portBusy), .portRsp(portRsp),
	.testRsp(testRsp), .csrRsp(csrRsp), .busy(busy)
);

ramIfPortUnit u_ramIfPortUnit (
	.sClk(sClk), .reset(reset),
	.ramEnable(ramEnable),
	.portReq(portReq), .portBusy(portBusy), .portRsp(portRsp),
	.sramPins(sramPins), .sramDq(sramDq)
);

endmodule

/* verilog/ramBlockPkg.sv */
package ramBlockPkg;

	//------------------------------
	// SRAM geometry
	//------------------------------
	// 256K x 16 asynchronous part
	localparam int ramAdrsWidth = 18;
	localparam int ramDqWidth = 16;

	//------------------------------
	// Register map
	//------------------------------
	// Word offsets inside the block window
	localparam int regOfsWidth = 3;
	localparam logic [regOfsWidth-1:0] regCtrl   = 3'd0;
	localparam logic [regOfsWidth-1:0] regStatus = 3'd1;
	localparam logic [regOfsWidth-1:0] regAdrs   = 3'd2;
	localparam logic [regOfsWidth-1:0] regWd     = 3'd3;
	localparam logic [regOfsWidth-1:0] regCmd    = 3'd4;
	localparam logic [regOfsWidth-1:0] regRd     = 3'd5;
	localparam logic [regOfsWidth-1:0] regSeed   = 3'd6;

	//------------------------------
	// Access types
	//------------------------------
	// Low write, high read
	typedef enum logic {
		ramWrite = 1'b0,
		ramRead  = 1'b1
	} ramCmdT;

	// One access toward the SRAM port
	typedef struct packed {
		logic valid;
		ramCmdT cmd;
		logic [ramAdrsWidth-1:0] adrs;
		logic [ramDqWidth-1:0] wd;
	} ramReqT;

	// Read return
	typedef struct packed {
		logic valid;
		logic [ramDqWidth-1:0] rd;
	} ramRspT;

	// Pin bundle, all strobes active low
	typedef struct packed {
		logic [ramAdrsWidth-1:0] adrs;
		logic [ramDqWidth-1:0] dq;
		logic dqOe;
		logic lbN;
		logic ubN;
		logic oeN;
		logic weN;
		logic ceN;
	} sramPinsT;

	// Self-test sequencer
	typedef enum logic [2:0] {
		testIdle,
		testWrite,
		testRead,
		testWait,
		testDone
	} testStateT;

endpackage

/* verilog/ramCsr.sv */
`timescale 1ns/1ns
module ramCsr import ramBlockPkg::*; #(
	parameter int pBlockAdrsWidth = 8,
	parameter logic [pBlockAdrsWidth-1:0] pAdrsMap = 8'h04,
	parameter int pBusWidth = 32
)(
	input  logic sClk,
	input  logic reset,
	// Bus side
	input  logic [pBusWidth-1:0] usiAdrs,
	input  logic [pBusWidth-1:0] usiWd,
	input  logic usiWe,
	output logic [pBusWidth-1:0] usiRd,
	// Tester control
	output logic testStart,
	output logic ramEnable,
	output logic [ramDqWidth-1:0] testSeed,
	input  logic testDone,
	input  logic testErr,
	// Direct access path
	output ramReqT csrReq,
	input  logic queueFull,
	input  ramRspT csrRsp,
	input  logic busy
);

logic blockHit;
logic wrHit;
logic [regOfsWidth-1:0] regOfs;
logic [ramAdrsWidth-1:0] adrsReg;
logic [ramDqWidth-1:0] wdReg;
logic [ramDqWidth-1:0] rdReg;
logic overflow;
logic [pBusWidth-1:0] rdMux;

//------------------------------
// Address decode
//------------------------------
// Upper bits pick the block, low bits the word
assign blockHit = (usiAdrs[pBusWidth-1 -: pBlockAdrsWidth] == pAdrsMap);
assign regOfs = usiAdrs[regOfsWidth-1:0];
assign wrHit = usiWe && blockHit;

//------------------------------
// Register writes
//------------------------------
always_ff @(posedge sClk)
begin
	if (reset)
	begin
		testStart <= 1'b0;
		// Port enabled out of reset
		ramEnable <= 1'b1;
		overflow <= 1'b0;
		csrReq.valid <= 1'b0;
	end
	else
	begin
		// Single-cycle pulses
		testStart <= wrHit && (regOfs == regCtrl) && usiWd[0];
		csrReq.valid <= wrHit && (regOfs == regCmd);
		if (wrHit && (regOfs == regCtrl))
		begin
			ramEnable <= usiWd[1];
		end
		// Sticky, a drop in the same cycle wins over the clear
		if (queueFull)
		begin
			overflow <= 1'b1;
		end
		else if (wrHit && (regOfs == regStatus))
		begin
			overflow <= 1'b0;
		end
		// Request payload from the staging registers
		if (wrHit && (regOfs == regCmd))
		begin
			csrReq.cmd <= ramCmdT'(usiWd[0]);
			csrReq.adrs <= adrsReg;
			csrReq.wd <= wdReg;
		end
	end
end

// Staging registers
always_ff @(posedge sClk)
begin
	if (wrHit && (regOfs == regAdrs))
	begin
		adrsReg <= usiWd[ramAdrsWidth-1:0];
	end
	if (wrHit && (regOfs == regWd))
	begin
		wdReg <= usiWd[ramDqWidth-1:0];
	end
	if (wrHit && (regOfs == regSeed))
	begin
		testSeed <= usiWd[ramDqWidth-1:0];
	end
	// Last direct read result
	if (csrRsp.valid)
	begin
		rdReg <= csrRsp.rd;
	end
end

//------------------------------
// Read mux
//------------------------------
always_comb
begin
	case (regOfs)
		regCtrl:   rdMux = pBusWidth'({ramEnable, 1'b0});
		regStatus: rdMux = pBusWidth'({overflow, busy, testErr, testDone});
		regAdrs:   rdMux = pBusWidth'(adrsReg);
		regWd:     rdMux = pBusWidth'(wdReg);
		regRd:     rdMux = pBusWidth'(rdReg);
		regSeed:   rdMux = pBusWidth'(testSeed);
		default:   rdMux = '0;
	endcase
end

// One cycle behind the address, zero outside the block
always_ff @(posedge sClk)
begin
	if (reset)
	begin
		usiRd <= '0;
	end
	else
	begin
		usiRd <= blockHit ? rdMux : '0;
	end
end

endmodule

/* verilog/ramIfPortUnit.sv */
`timescale 1ns/1ns
module ramIfPortUnit import ramBlockPkg::*; (
	input  logic sClk,
	input  logic reset,
	input  logic ramEnable,
	input  ramReqT portReq,
	output logic portBusy,
	output ramRspT portRsp,
	output sramPinsT sramPins,
	input  logic [ramDqWidth-1:0] sramDq
);

// Setup phase then strobe phase
typedef enum logic [1:0] {
	portIdle,
	portSetup,
	portStrobe
} portStateT;

portStateT state;
ramCmdT cmdQ;
logic [ramAdrsWidth-1:0] adrsQ;
logic [ramDqWidth-1:0] wdQ;
logic [ramDqWidth-1:0] rdQ;
logic rspValid;
logic dqOe;
logic oeN;
logic weN;
logic ceN;

//------------------------------
// Pin sequencer
//------------------------------
always_ff @(posedge sClk)
begin
	if (reset)
	begin
		state <= portIdle;
		dqOe <= 1'b0;
		oeN <= 1'b1;
		weN <= 1'b1;
		ceN <= 1'b1;
		rspValid <= 1'b0;
	end
	else
	begin
		rspValid <= 1'b0;
		case (state)
			portIdle:
			begin
				if (portReq.valid && ramEnable)
				begin
					state <= portSetup;
					ceN <= 1'b0;
					// Drive dq across both cycles of a write
					dqOe <= (portReq.cmd == ramWrite);
				end
			end
			portSetup:
			begin
				state <= portStrobe;
				weN <= (cmdQ != ramWrite);
				oeN <= (cmdQ != ramRead);
			end
			default:
			begin
				// Release everything, read data returns next cycle
				state <= portIdle;
				weN <= 1'b1;
				oeN <= 1'b1;
				ceN <= 1'b1;
				dqOe <= 1'b0;
				rspValid <= (cmdQ == ramRead);
			end
		endcase
	end
end

// Address, data and capture
always_ff @(posedge sClk)
begin
	if ((state == portIdle) && portReq.valid && ramEnable)
	begin
		cmdQ <= portReq.cmd;
		adrsQ <= portReq.adrs;
		wdQ <= portReq.wd;
	end
	if (state == portStrobe)
	begin
		rdQ <= sramDq;
	end
end

//------------------------------
// Outputs
//------------------------------
// Disabled port looks busy so nothing is granted
assign portBusy = (state != portIdle) || !ramEnable;
assign portRsp.valid = rspValid;
assign portRsp.rd = rdQ;

always_comb
begin
	sramPins.adrs = adrsQ;
	sramPins.dq = wdQ;
	sramPins.dqOe = dqOe;
	// Both byte lanes always on
	sramPins.lbN = 1'b0;
	sramPins.ubN = 1'b0;
	sramPins.oeN = oeN;
	sramPins.weN = weN;
	sramPins.ceN = ceN || !ramEnable;
end

weOeExclusive: assert property (@(posedge sClk) disable iff (reset)
	!(!sramPins.weN && !sramPins.oeN))
	else $error("write enable and output enable both active");

endmodule

/* verilog/ramReadWriteArbiter.sv */
`timescale 1ns/1ns
module ramReadWriteArbiter import ramBlockPkg::*; #(
	parameter int pFifoDepth = 4
)(
	input  logic sClk,
	input  logic reset,
	// Direct access side
	input  ramReqT csrReq,
	output logic queueFull,
	// Tester side
	input  ramReqT testReq,
	input  logic testActive,
	output logic testGrant,
	// Port side
	output ramReqT portReq,
	input  logic portBusy,
	input  ramRspT portRsp,
	// Responses
	output ramRspT testRsp,
	output ramRspT csrRsp,
	output logic busy
);

localparam int lpPtrWidth = (pFifoDepth > 1) ? $clog2(pFifoDepth) : 1;
localparam int lpCntWidth = $clog2(pFifoDepth + 1);

ramReqT queueMem [pFifoDepth];
logic [lpPtrWidth-1:0] wrPtr;
logic [lpPtrWidth-1:0] rdPtr;
logic [lpCntWidth-1:0] count;
logic full;
logic empty;
logic push;
logic queueGrant;

// Wrap for any depth
function automatic logic [lpPtrWidth-1:0] nextPtr(input logic [lpPtrWidth-1:0] ptr);
	return (ptr == lpPtrWidth'(pFifoDepth - 1)) ? '0 : ptr + 1'b1;
endfunction

//------------------------------
// Request queue
//------------------------------
assign full = (count == lpCntWidth'(pFifoDepth));
assign empty = (count == '0);
// Full queue drops the request
assign push = csrReq.valid && !full;
assign queueFull = csrReq.valid && full;

always_ff @(posedge sClk)
begin
	if (push)
	begin
		queueMem[wrPtr] <= csrReq;
	end
end

always_ff @(posedge sClk)
begin
	if (reset)
	begin
		wrPtr <= '0;
		rdPtr <= '0;
		count <= '0;
	end
	else
	begin
		if (push)
		begin
			wrPtr <= nextPtr(wrPtr);
		end
		if (queueGrant)
		begin
			rdPtr <= nextPtr(rdPtr);
		end
		case ({push, queueGrant})
			2'b10:   count <= count + 1'b1;
			2'b01:   count <= count - 1'b1;
			default: count <= count;
		endcase
	end
end

//------------------------------
// Arbitration
//------------------------------
// Tester owns the port for its whole run
assign testGrant = testActive && !portBusy;
assign queueGrant = !testActive && !portBusy && !empty;

always_comb
begin
	if (testActive)
	begin
		portReq = testReq;
		portReq.valid = testReq.valid && testGrant;
	end
	else
	begin
		portReq = queueMem[rdPtr];
		portReq.valid = queueGrant;
	end
end

// Single access in flight, so steer by owner
always_comb
begin
	testRsp = portRsp;
	csrRsp = portRsp;
	testRsp.valid = portRsp.valid && testActive;
	csrRsp.valid = portRsp.valid && !testActive;
end

assign busy = !empty || portBusy;

queueCountBound: assert property (@(posedge sClk) disable iff (reset)
	count <= lpCntWidth'(pFifoDepth))
	else $error("request queue count above depth");

endmodule
